// File: rtl/audio_ctrl_defines.svh
`ifndef AUDIO_CTRL_DEFINES_SVH
`define AUDIO_CTRL_DEFINES_SVH

// ==================================================
// Host protocol widths
// ==================================================

// Every byte moved through the host FIFOs and the sample sink
`define AC_BYTE_W 8

// Payload length field in the low bits of a header byte
`define AC_LEN_W 6

// ==================================================
// Reply framing
// ==================================================

// Stop opcode (2'b11) with a payload length of one
`define AC_REPLY_HDR 8'hC1

// Error byte values carried in the second reply byte
`define AC_ERR_NONE 8'h00
`define AC_ERR_SETUP_LEN 8'h01
`define AC_ERR_STOP_LEN 8'h02

// ==================================================
// Clock domain crossing
// ==================================================

// Flops on the transmitter streaming level
`define AC_SYNC_STAGES 2

`endif

// File: rtl/audio_ctrl_pkg.sv
`include "audio_ctrl_defines.svh"

package audio_ctrl_pkg;

    // Host opcode in header bits 7:6
    typedef enum logic [1:0] {
        OP_SETUP_OUTPUT = 2'd0,
        OP_SETUP_INPUT  = 2'd1,
        OP_STREAM_OUTPUT = 2'd2,
        OP_STOP         = 2'd3
    } cmd_op_e;

    // Physical output type, setup byte bits 7:6
    // First three are all S/PDIF flavours
    typedef enum logic [1:0] {
        IO_AES3    = 2'd0,
        IO_BNC     = 2'd1,
        IO_TOSLINK = 2'd2,
        IO_I2S     = 2'd3
    } io_type_e;

    // Bit 2 selects the 48 kHz family over the 44.1 kHz family
    typedef enum logic [2:0] {
        SR_44100  = 3'b000,
        SR_88200  = 3'b001,
        SR_176400 = 3'b010,
        SR_352800 = 3'b011,
        SR_48000  = 3'b100,
        SR_96000  = 3'b101,
        SR_192000 = 3'b110,
        SR_384000 = 3'b111
    } sample_rate_e;

    // Sample word size, DoP is DSD over PCM
    typedef enum logic [1:0] {
        BD_DOP = 2'd0,
        BD_16  = 2'd1,
        BD_24  = 2'd2,
        BD_32  = 2'd3
    } bit_depth_e;

    // Second byte of every reply
    typedef enum logic [`AC_BYTE_W-1:0] {
        ERR_NONE      = `AC_ERR_NONE,
        ERR_SETUP_LEN = `AC_ERR_SETUP_LEN,
        ERR_STOP_LEN  = `AC_ERR_STOP_LEN
    } err_code_e;

    // Execute FSM
    typedef enum logic [1:0] {EX_RUN, EX_WAIT_STOP, EX_REPLY, EX_HALTED} exec_state_e;

    // Decode FSM
    typedef enum logic [1:0] {DEC_HEADER, DEC_PAYLOAD, DEC_HOLD} dec_state_e;

endpackage

// File: rtl/host_cmd_if.sv
`include "audio_ctrl_defines.svh"

interface host_cmd_if;
    import audio_ctrl_pkg::*;

    // Header event, op/len/len_ok valid with the pulse and held after
    logic                 hdr_valid;
    cmd_op_e              op;
    logic [`AC_LEN_W-1:0] len;
    logic                 len_ok;

    // One payload byte per pulse, op still names its frame
    logic                  pay_valid;
    logic [`AC_BYTE_W-1:0] pay_data;

    // Release decode from HOLD once a stop is answered
    logic resume;

    modport decode (
        output hdr_valid, op, len, len_ok, pay_valid, pay_data,
        input  resume
    );

    modport execute (
        input  hdr_valid, op, len, len_ok, pay_valid, pay_data,
        output resume
    );
endinterface

// File: rtl/cmd_decode.sv
`include "audio_ctrl_defines.svh"

module cmd_decode (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  in_fifo_empty_i,
    input  logic [`AC_BYTE_W-1:0] in_fifo_data_i,
    input  logic                  sample_full_i,
    output logic                  in_fifo_rd_en_o,
    host_cmd_if.decode            cmd
);
    import audio_ctrl_pkg::*;

    dec_state_e           state_q;
    // Payload bytes still to come in the current frame
    logic [`AC_LEN_W-1:0] remain_q;

    // Header fields straight off the show-ahead FIFO
    cmd_op_e              hdr_op;
    logic [`AC_LEN_W-1:0] hdr_len;
    logic                 hdr_len_ok;

    logic rd_hdr;
    logic rd_pay;

    // ==================================================
    // Read strobe
    // ==================================================

    // Show-ahead FIFO, the byte is consumed in the cycle of the strobe
    // Sink almost-full also blocks headers, keeps the pipeline simple
    assign in_fifo_rd_en_o = !in_fifo_empty_i && !sample_full_i && (state_q != DEC_HOLD);

    // Tag the consumed byte
    assign rd_hdr = in_fifo_rd_en_o && (state_q == DEC_HEADER);
    assign rd_pay = in_fifo_rd_en_o && (state_q == DEC_PAYLOAD);

    assign hdr_op  = cmd_op_e'(in_fifo_data_i[`AC_BYTE_W-1 -: 2]);
    assign hdr_len = in_fifo_data_i[`AC_LEN_W-1:0];

    // Length rule, only setup output and stop have a fixed size
    always_comb begin
        case (hdr_op)
            OP_SETUP_OUTPUT: hdr_len_ok = (hdr_len == `AC_LEN_W'(1));
            OP_STOP:         hdr_len_ok = (hdr_len == '0);
            default:         hdr_len_ok = 1'b1;
        endcase
    end

    // ==================================================
    // Frame FSM
    // ==================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q  <= DEC_HEADER;
            remain_q <= '0;
        end else begin
            case (state_q)
                DEC_HEADER: begin
                    if (rd_hdr) begin
                        remain_q <= hdr_len;
                        // Stop and bad lengths wait for execute
                        if (hdr_op == OP_STOP || !hdr_len_ok) begin
                            state_q <= DEC_HOLD;
                        end else if (hdr_len != '0) begin
                            state_q <= DEC_PAYLOAD;
                        end
                    end
                end

                DEC_PAYLOAD: begin
                    if (rd_pay) begin
                        remain_q <= remain_q - `AC_LEN_W'(1);
                        // Last payload byte closes the frame
                        if (remain_q == `AC_LEN_W'(1)) begin
                            state_q <= DEC_HEADER;
                        end
                    end
                end

                DEC_HOLD: begin
                    // After an error no resume ever comes
                    if (cmd.resume) begin
                        state_q <= DEC_HEADER;
                    end
                end

                default: state_q <= DEC_HEADER;
            endcase
        end
    end

    // ==================================================
    // Interface registers
    // ==================================================

    // Event strobes, one cycle after the read
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            cmd.hdr_valid <= 1'b0;
            cmd.pay_valid <= 1'b0;
        end else begin
            cmd.hdr_valid <= rd_hdr;
            cmd.pay_valid <= rd_pay;
        end
    end

    // Header fields held for the rest of the frame
    always_ff @(posedge clk) begin
        if (rd_hdr) begin
            cmd.op     <= hdr_op;
            cmd.len    <= hdr_len;
            cmd.len_ok <= hdr_len_ok;
        end
        if (rd_pay) begin
            cmd.pay_data <= in_fifo_data_i;
        end
    end

endmodule

// File: rtl/cmd_execute.sv
`include "audio_ctrl_defines.svh"

module cmd_execute (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         streaming_i,
    input  logic                         reply_done_i,
    output logic                         sample_wr_en_o,
    output logic [`AC_BYTE_W-1:0]        sample_data_o,
    output logic                         spdif_en_o,
    output logic                         i2s_en_o,
    output audio_ctrl_pkg::sample_rate_e sample_rate_o,
    output audio_ctrl_pkg::bit_depth_e   bit_depth_o,
    output logic                         stereo_o,
    output logic                         error_o,
    output logic                         reply_start_o,
    output audio_ctrl_pkg::err_code_e    reply_code_o,
    host_cmd_if.execute                  cmd
);
    import audio_ctrl_pkg::*;

    logic [`AC_SYNC_STAGES-1:0] sync_q;
    logic                       streaming_s;
    exec_state_e                state_q;
    io_type_e                   io_type;
    logic                       start_err;
    logic                       start_ok;

    // Transmitter level from the audio clock domain
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`AC_SYNC_STAGES-2:0], streaming_i};
        end
    end
    assign streaming_s = sync_q[`AC_SYNC_STAGES-1];

    // ==================================================
    // Payload handling
    // ==================================================

    assign io_type = io_type_e'(cmd.pay_data[7:6]);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            spdif_en_o    <= 1'b0;
            i2s_en_o      <= 1'b0;
            stereo_o      <= 1'b0;
            sample_rate_o <= SR_44100;
            bit_depth_o   <= BD_DOP;
        end else if (cmd.pay_valid && cmd.op == OP_SETUP_OUTPUT) begin
            // AES3, BNC and TOSLINK all drive the S/PDIF path
            case (io_type)
                IO_I2S: begin
                    spdif_en_o <= 1'b0;
                    i2s_en_o   <= 1'b1;
                end
                default: begin
                    spdif_en_o <= 1'b1;
                    i2s_en_o   <= 1'b0;
                end
            endcase
            stereo_o      <= cmd.pay_data[5];
            sample_rate_o <= sample_rate_e'(cmd.pay_data[4:2]);
            bit_depth_o   <= bit_depth_e'(cmd.pay_data[1:0]);
        end
    end

    // Stream bytes go to the sink, setup input payloads are dropped here
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            sample_wr_en_o <= 1'b0;
        end else begin
            sample_wr_en_o <= cmd.pay_valid && (cmd.op == OP_STREAM_OUTPUT);
        end
    end

    always_ff @(posedge clk) begin
        sample_data_o <= cmd.pay_data;
    end

    // ==================================================
    // Command FSM
    // ==================================================

    // Bad length answers right away
    assign start_err = (state_q == EX_RUN) && cmd.hdr_valid && !cmd.len_ok;
    // Good stop answers once the transmitter has drained
    assign start_ok  = !streaming_s && ((state_q == EX_WAIT_STOP) ||
        ((state_q == EX_RUN) && cmd.hdr_valid && cmd.len_ok && cmd.op == OP_STOP));

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q       <= EX_RUN;
            reply_start_o <= 1'b0;
            error_o       <= 1'b0;
            cmd.resume    <= 1'b0;
        end else begin
            reply_start_o <= start_err || start_ok;
            cmd.resume    <= 1'b0;
            case (state_q)
                EX_RUN: begin
                    if (start_err) begin
                        error_o <= 1'b1;
                        state_q <= EX_REPLY;
                    end else if (start_ok) begin
                        state_q <= EX_REPLY;
                    end else if (cmd.hdr_valid && cmd.op == OP_STOP) begin
                        state_q <= EX_WAIT_STOP;
                    end
                end
                EX_WAIT_STOP: begin
                    if (start_ok) begin
                        state_q <= EX_REPLY;
                    end
                end
                EX_REPLY: begin
                    if (reply_done_i) begin
                        if (error_o) begin
                            state_q <= EX_HALTED;
                        end else begin
                            cmd.resume <= 1'b1;
                            state_q    <= EX_RUN;
                        end
                    end
                end
                // Only a reset leaves here
                default: state_q <= EX_HALTED;
            endcase
        end
    end

    // Code captured with the start pulse
    always_ff @(posedge clk) begin
        if (start_err) begin
            reply_code_o <= (cmd.op == OP_STOP) ? ERR_STOP_LEN : ERR_SETUP_LEN;
        end else if (start_ok) begin
            reply_code_o <= ERR_NONE;
        end
    end

endmodule

// File: rtl/status_reply.sv
`include "audio_ctrl_defines.svh"

module status_reply (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      reply_start_i,
    input  audio_ctrl_pkg::err_code_e reply_code_i,
    input  logic                      out_fifo_full_i,
    input  logic                      out_fifo_afull_i,
    output logic                      out_fifo_wr_en_o,
    output logic [`AC_BYTE_W-1:0]     out_fifo_data_o,
    output logic                      reply_done_o
);

    // Header then error code
    logic [`AC_BYTE_W-1:0] reply_buf [0:1];
    logic                  idx_q;
    logic                  busy_q;
    logic                  fifo_free;
    logic                  send;

    // Host FIFO flags are sampled one cycle ahead of the write
    assign fifo_free = !out_fifo_full_i && !out_fifo_afull_i;
    assign send      = busy_q && fifo_free;

    // Load the buffer on start
    always_ff @(posedge clk) begin
        if (reply_start_i) begin
            reply_buf[0] <= `AC_REPLY_HDR;
            reply_buf[1] <= reply_code_i;
        end
    end

    // ==================================================
    // Byte sequencer
    // ==================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_q           <= 1'b0;
            idx_q            <= 1'b0;
            out_fifo_wr_en_o <= 1'b0;
            reply_done_o     <= 1'b0;
        end else begin
            out_fifo_wr_en_o <= 1'b0;
            reply_done_o     <= 1'b0;
            if (reply_start_i) begin
                busy_q <= 1'b1;
                idx_q  <= 1'b0;
            end else if (send) begin
                out_fifo_wr_en_o <= 1'b1;
                idx_q            <= !idx_q;
                // Done rides along with the code byte
                if (idx_q) begin
                    busy_q       <= 1'b0;
                    reply_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_fifo_data_o <= reply_buf[idx_q];
        end
    end

endmodule

// File: rtl/audio_ctrl.sv
`include "audio_ctrl_defines.svh"

module audio_ctrl (
    input  logic                         clk,
    input  logic                         reset_i,
    // Host input FIFO, show-ahead
    input  logic                         in_fifo_empty_i,
    input  logic [`AC_BYTE_W-1:0]        in_fifo_data_i,
    output logic                         in_fifo_rd_en_o,
    // Audio sample sink
    input  logic                         sample_full_i,
    input  logic                         streaming_i,
    output logic                         sample_wr_en_o,
    output logic [`AC_BYTE_W-1:0]        sample_data_o,
    // Host output FIFO
    input  logic                         out_fifo_full_i,
    input  logic                         out_fifo_afull_i,
    output logic                         out_fifo_wr_en_o,
    output logic [`AC_BYTE_W-1:0]        out_fifo_data_o,
    // Output configuration
    output logic                         spdif_en_o,
    output logic                         i2s_en_o,
    output audio_ctrl_pkg::sample_rate_e sample_rate_o,
    output audio_ctrl_pkg::bit_depth_e   bit_depth_o,
    output logic                         stereo_o,
    output logic                         error_o
);
    import audio_ctrl_pkg::*;

    logic      reply_start;
    err_code_e reply_code;
    logic      reply_done;

    host_cmd_if cmd_if ();

    // Framing of the host byte stream
    cmd_decode i_decode (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_fifo_empty_i (in_fifo_empty_i),
        .in_fifo_data_i  (in_fifo_data_i),
        .sample_full_i   (sample_full_i),
        .in_fifo_rd_en_o (in_fifo_rd_en_o),
        .cmd             (cmd_if.decode)
    );

    // Configuration, streaming and stop handling
    cmd_execute i_execute (
        .clk            (clk),
        .reset_i        (reset_i),
        .streaming_i    (streaming_i),
        .reply_done_i   (reply_done),
        .sample_wr_en_o (sample_wr_en_o),
        .sample_data_o  (sample_data_o),
        .spdif_en_o     (spdif_en_o),
        .i2s_en_o       (i2s_en_o),
        .sample_rate_o  (sample_rate_o),
        .bit_depth_o    (bit_depth_o),
        .stereo_o       (stereo_o),
        .error_o        (error_o),
        .reply_start_o  (reply_start),
        .reply_code_o   (reply_code),
        .cmd            (cmd_if.execute)
    );

    // Two-byte answer to the host
    status_reply i_reply (
        .clk              (clk),
        .reset_i          (reset_i),
        .reply_start_i    (reply_start),
        .reply_code_i     (reply_code),
        .out_fifo_full_i  (out_fifo_full_i),
        .out_fifo_afull_i (out_fifo_afull_i),
        .out_fifo_wr_en_o (out_fifo_wr_en_o),
        .out_fifo_data_o  (out_fifo_data_o),
        .reply_done_o     (reply_done)
    );

endmodule

// File: sim/audio_ctrl_assert.sv
module audio_ctrl_assert (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        in_fifo_rd_en_i,
    input logic                        in_fifo_empty_i,
    input logic                        out_fifo_full_i,
    input logic                        out_fifo_afull_i,
    input logic                        out_fifo_wr_en_i,
    input logic                        error_i,
    input logic                        sample_wr_en_i,
    input audio_ctrl_pkg::exec_state_e exec_state_i
);
    import audio_ctrl_pkg::*;

    // Failed property count
    int fail_count = 0;

    // ==================================================
    // Protocol properties
    // ==================================================

    // Reads need valid show-ahead data and an execute FSM that is running
    rd_needs_data: assert property (@(posedge clk) disable iff (reset_i)
        in_fifo_rd_en_i |-> !in_fifo_empty_i && (exec_state_i == EX_RUN))
    else begin
        $error("input FIFO read while empty or while execute was not running");
        fail_count++;
    end

    // Reply bytes follow a free host FIFO cycle and stay inside REPLY
    reply_obeys_flags: assert property (@(posedge clk) disable iff (reset_i)
        out_fifo_wr_en_i |-> $past(!out_fifo_full_i && !out_fifo_afull_i) &&
            (exec_state_i == EX_REPLY))
    else begin
        $error("reply byte written after a full cycle or outside the reply state");
        fail_count++;
    end

    // Error stays set until reset and the sink goes quiet after it
    error_sticky: assert property (@(posedge clk) disable iff (reset_i)
        error_i |=> error_i && !sample_wr_en_i)
    else begin
        $error("error_o dropped without reset or a sample write followed the error");
        fail_count++;
    end

    // Halted controller is silent toward the sink
    halted_silent: assert property (@(posedge clk) disable iff (reset_i)
        (exec_state_i == EX_HALTED) |-> !sample_wr_en_i)
    else begin
        $error("sample write while execute is halted");
        fail_count++;
    end

endmodule

bind audio_ctrl audio_ctrl_assert i_assert (
    .clk              (clk),
    .reset_i          (reset_i),
    .in_fifo_rd_en_i  (in_fifo_rd_en_o),
    .in_fifo_empty_i  (in_fifo_empty_i),
    .out_fifo_full_i  (out_fifo_full_i),
    .out_fifo_afull_i (out_fifo_afull_i),
    .out_fifo_wr_en_i (out_fifo_wr_en_o),
    .error_i          (error_o),
    .sample_wr_en_i   (sample_wr_en_o),
    .exec_state_i     (i_execute.state_q)
);

// File: sim/audio_ctrl_tb.sv
`include "audio_ctrl_defines.svh"

module audio_ctrl_tb;
    import audio_ctrl_pkg::*;

    // Expected controller state after a frame
    typedef struct packed {
        logic         spdif;
        logic         i2s;
        sample_rate_e rate;
        bit_depth_e   depth;
        logic         stereo;
        logic         cfg_known;
        logic         fwd;
        logic         reply;
        err_code_e    code;
        logic         err;
    } ref_t;

    // Stop opcode with a length of one
    localparam logic [`AC_BYTE_W-1:0] reply_hdr = {2'b11, 6'd1};

    logic                  clk;
    logic                  reset_i;
    logic                  in_fifo_empty_i;
    logic [`AC_BYTE_W-1:0] in_fifo_data_i;
    logic                  in_fifo_rd_en_o;
    logic                  sample_full_i;
    logic                  streaming_i;
    logic                  sample_wr_en_o;
    logic [`AC_BYTE_W-1:0] sample_data_o;
    logic                  out_fifo_full_i;
    logic                  out_fifo_afull_i;
    logic                  out_fifo_wr_en_o;
    logic [`AC_BYTE_W-1:0] out_fifo_data_o;
    logic                  spdif_en_o;
    logic                  i2s_en_o;
    sample_rate_e          sample_rate_o;
    bit_depth_e            bit_depth_o;
    logic                  stereo_o;
    logic                  error_o;

    // Host FIFO model and expectation queues
    logic [`AC_BYTE_W-1:0] in_q [$];
    logic [`AC_BYTE_W-1:0] pay_q [$];
    logic [`AC_BYTE_W-1:0] exp_samples [$];
    logic [`AC_BYTE_W-1:0] exp_reply [$];
    ref_t                  exp_state;

    // Stimulus knobs, applied by the FIFO model
    logic        stream_req;
    logic        sink_stall;
    logic        host_stall;
    logic [31:0] lfsr_q;

    int total_bytes = 0;
    int cycle_count = 0;
    int rd_count = 0;
    int reply_count = 0;

    audio_ctrl i_dut (.*);

    always #10 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        logic       fb;
        int         k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[6:0], fb};
        end
        return v;
    endfunction

    function automatic ref_t reset_ref();
        ref_t r;
        r           = '0;
        r.rate      = SR_44100;
        r.depth     = BD_DOP;
        r.code      = ERR_NONE;
        return r;
    endfunction

    // Frame rules: header op in 7:6, length in 5:0
    function automatic ref_t expected_frame(input logic [7:0] hdr, input logic [7:0] pay0,
                                            input ref_t prev);
        ref_t       r;
        logic [1:0] op;
        logic [5:0] len;
        r       = prev;
        r.fwd   = 1'b0;
        r.reply = 1'b0;
        r.code  = ERR_NONE;
        op      = hdr[7:6];
        len     = hdr[5:0];
        // Halted until reset, nothing is read
        if (prev.err) begin
            return r;
        end
        case (op)
            2'd0: begin
                if (len != 6'd1) begin
                    r.reply = 1'b1;
                    r.code  = ERR_SETUP_LEN;
                    r.err   = 1'b1;
                end else begin
                    // Type 3 is I2S, the rest are S/PDIF
                    r.spdif     = (pay0[7:6] != 2'd3);
                    r.i2s       = (pay0[7:6] == 2'd3);
                    r.stereo    = pay0[5];
                    r.rate      = sample_rate_e'(pay0[4:2]);
                    r.depth     = bit_depth_e'(pay0[1:0]);
                    r.cfg_known = 1'b1;
                end
            end
            2'd2: r.fwd = 1'b1;
            2'd3: begin
                r.reply = 1'b1;
                r.code  = (len == 6'd0) ? ERR_NONE : ERR_STOP_LEN;
                r.err   = (len != 6'd0);
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic abort_run;
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%02h exp=%02h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%b exp=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rate(input string name, input sample_rate_e got,
                              input sample_rate_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%s exp=%s", $time, name,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_depth(input string name, input bit_depth_e got, input bit_depth_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s got=%s exp=%s", $time, name,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_state;
        check_bit("spdif_en_o", spdif_en_o, exp_state.spdif);
        check_bit("i2s_en_o", i2s_en_o, exp_state.i2s);
        check_bit("error_o", error_o, exp_state.err);
        if (exp_state.cfg_known) begin
            check_bit("stereo_o", stereo_o, exp_state.stereo);
            check_rate("sample_rate_o", sample_rate_o, exp_state.rate);
            check_depth("bit_depth_o", bit_depth_o, exp_state.depth);
        end
    endtask

    // Queue a header plus pay_q and record what should come back
    task automatic send_frame(input logic [7:0] hdr);
        ref_t       r;
        logic [7:0] first;
        @(posedge clk);
        first = (pay_q.size() > 0) ? pay_q[0] : 8'h00;
        r     = expected_frame(hdr, first, exp_state);
        in_q.push_back(hdr);
        total_bytes++;
        foreach (pay_q[k]) begin
            in_q.push_back(pay_q[k]);
            total_bytes++;
            if (r.fwd) begin
                exp_samples.push_back(pay_q[k]);
            end
        end
        if (r.reply) begin
            exp_reply.push_back(reply_hdr);
            exp_reply.push_back(r.code);
        end
        exp_state = r;
        pay_q.delete();
    endtask

    // All expected traffic seen, then settle and check the levels
    task automatic wait_idle;
        do begin
            @(posedge clk);
        end while (exp_samples.size() != 0 || exp_reply.size() != 0 ||
                   (in_q.size() != 0 && !exp_state.err));
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_state();
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #2;
        reset_i = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(posedge clk);
    endtask

    // ==================================================
    // FIFO model and compare process
    // ==================================================

    always begin : fifo_model
        logic rd_seen;
        // Outputs are stable at the falling edge
        @(negedge clk);
        rd_seen = in_fifo_rd_en_o;
        if (rd_seen) begin
            rd_count++;
        end
        if (i_dut.i_assert.fail_count != 0) begin
            $display("A bound assertion failed at time %0t", $time);
            abort_run();
        end
        if (!reset_i && sample_wr_en_o) begin
            if (exp_samples.size() == 0) begin
                $display("Sample write at time %0t with no stream byte pending", $time);
                abort_run();
            end
            check_byte("sample_data_o", sample_data_o, exp_samples.pop_front());
        end
        if (!reset_i && out_fifo_wr_en_o) begin
            reply_count++;
            if (exp_reply.size() == 0) begin
                $display("Reply write at time %0t with no reply expected", $time);
                abort_run();
            end
            check_byte("out_fifo_data_o", out_fifo_data_o, exp_reply.pop_front());
        end
        // Inputs change just after the rising edge
        @(posedge clk);
        #2;
        if (rd_seen) begin
            void'(in_q.pop_front());
        end
        in_fifo_empty_i  = (in_q.size() == 0);
        in_fifo_data_i   = (in_q.size() > 0) ? in_q[0] : 8'h00;
        streaming_i      = stream_req;
        sample_full_i    = sink_stall ? (lfsr_bits(1) != 8'd0) : 1'b0;
        out_fifo_full_i  = host_stall ? (lfsr_bits(1) != 8'd0) : 1'b0;
        out_fifo_afull_i = host_stall ? (lfsr_bits(1) != 8'd0) : 1'b0;
    end

    // Limit grows with the queued traffic
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * total_bytes + 2000) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            abort_run();
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin : main
        int         t;
        int         rd_before;
        int         left_before;
        int         replies_before;
        logic [7:0] rb;

        clk              = 1'b0;
        reset_i          = 1'b1;
        in_fifo_empty_i  = 1'b1;
        in_fifo_data_i   = 8'h00;
        sample_full_i    = 1'b0;
        streaming_i      = 1'b0;
        out_fifo_full_i  = 1'b0;
        out_fifo_afull_i = 1'b0;
        stream_req       = 1'b0;
        sink_stall       = 1'b0;
        host_stall       = 1'b0;
        lfsr_q           = 32'h2a17a1ec;
        exp_state        = reset_ref();
        apply_reset();
        @(negedge clk);
        check_state();

        // Setup output for each output type
        for (t = 0; t < 4; t++) begin
            rb = lfsr_bits(6);
            pay_q.push_back({2'(t), rb[5:0]});
            send_frame(8'h01);
            wait_idle();
        end

        // Stream with random sink stalls
        sink_stall = 1'b1;
        for (t = 0; t < 24; t++) begin
            pay_q.push_back(lfsr_bits(8));
        end
        send_frame({2'b10, 6'd24});
        wait_idle();
        sink_stall = 1'b0;

        // Stop while the transmitter is still streaming
        stream_req = 1'b1;
        for (t = 0; t < 4; t++) begin
            pay_q.push_back(lfsr_bits(8));
        end
        send_frame(8'h84);
        send_frame(8'hC0);
        do begin
            @(posedge clk);
        end while (in_q.size() != 0 || exp_samples.size() != 0);
        replies_before = reply_count;
        repeat (30) @(posedge clk);
        if (reply_count != replies_before) begin
            $display("Reply written at time %0t while streaming_i was high", $time);
            abort_run();
        end
        stream_req = 1'b0;
        for (t = 0; t < 3; t++) begin
            pay_q.push_back(lfsr_bits(8));
        end
        send_frame(8'h83);
        wait_idle();

        // Reply under host back-pressure
        host_stall = 1'b1;
        send_frame(8'hC0);
        wait_idle();
        host_stall = 1'b0;

        // Setup input is swallowed
        for (t = 0; t < 3; t++) begin
            pay_q.push_back(lfsr_bits(8));
        end
        send_frame(8'h43);
        wait_idle();

        // Stop with a bad length halts, later bytes stay queued
        pay_q.push_back(8'h5a);
        pay_q.push_back(8'ha5);
        send_frame(8'hC2);
        pay_q.push_back(8'h11);
        pay_q.push_back(8'h22);
        send_frame(8'h82);
        wait_idle();
        rd_before   = rd_count;
        left_before = in_q.size();
        repeat (50) @(posedge clk);
        if (rd_count != rd_before || in_q.size() != left_before) begin
            $display("Input FIFO read at time %0t after the error halt", $time);
            abort_run();
        end

        // Fresh reset, then a setup with a bad length
        in_q.delete();
        exp_state = reset_ref();
        apply_reset();
        for (t = 0; t < 3; t++) begin
            pay_q.push_back(lfsr_bits(8));
        end
        send_frame(8'h03);
        wait_idle();

        if (i_dut.i_assert.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("A bound assertion failed during the run");
            abort_run();
        end
    end

endmodule

// File: audio_ctrl.f
+incdir+rtl
rtl/audio_ctrl_pkg.sv
rtl/host_cmd_if.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/status_reply.sv
rtl/audio_ctrl.sv
sim/audio_ctrl_assert.sv
sim/audio_ctrl_tb.sv

// File: Makefile
# Verilator flow for the audio bridge host-command controller

VERILATOR ?= verilator
TOP       ?= audio_ctrl_tb
FILELIST  ?= audio_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status of the simulator is ignored, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
